/* vlog.f */
+incdir+include
source/csr_pkg.sv
source/csr_decode.sv
source/csr_execute.sv
source/csr_result.sv
source/csr_unit.sv
tests/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module csr_unit_tb -o csr_unit_tb
./obj_dir/csr_unit_tb | tee sim.log

if grep -q "Result: PASSED" sim.log; then
   exit 0
fi
exit 1

/* include/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// reference csr state, updated once per accepted request
logic [31:0] model_mstatus  = '0;
logic [31:0] model_medeleg  = '0;
logic [31:0] model_mideleg  = '0;
logic [31:0] model_mie      = '0;
logic [31:0] model_mtvec    = '0;
logic [31:0] model_mscratch = '0;
logic [31:0] model_mepc     = '0;
logic [31:0] model_mcause   = '0;
logic [31:0] model_mtval    = '0;
logic [63:0] model_instret  = '0;

function automatic csr_pkg::csr_resp_t predict_resp(input csr_pkg::csr_req_t req);
   csr_pkg::csr_resp_t r;
   logic [11:0] addr;
   logic [2:0]  f3;
   logic [4:0]  rs1;
   logic [31:0] opnd;
   logic [31:0] old;
   logic [31:0] nv;
   bit          known;
   bit          rd_en;
   bit          wr_en;
   bit          legal;
   addr = req.instr[31:20];
   f3 = req.instr[14:12];
   rs1 = req.instr[19:15];
   opnd = f3[2] ? {27'b0, rs1} : req.rs1_value;
   known = 1'b1;
   case (addr)
      csr_pkg::ADDR_SSTATUS:  old = model_mstatus & csr_pkg::SSTATUS_MASK;
      csr_pkg::ADDR_SIE:      old = model_mie & model_mideleg;
      csr_pkg::ADDR_MSTATUS:  old = model_mstatus;
      csr_pkg::ADDR_MISA:     old = csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MEDELEG:  old = model_medeleg;
      csr_pkg::ADDR_MIDELEG:  old = model_mideleg;
      csr_pkg::ADDR_MIE:      old = model_mie;
      csr_pkg::ADDR_MTVEC:    old = model_mtvec;
      csr_pkg::ADDR_MSCRATCH: old = model_mscratch;
      csr_pkg::ADDR_MEPC:     old = model_mepc;
      csr_pkg::ADDR_MCAUSE:   old = model_mcause;
      csr_pkg::ADDR_MTVAL:    old = model_mtval;
      csr_pkg::ADDR_MHARTID:  old = HART_ID;
      csr_pkg::ADDR_INSTRET:  old = model_instret[31:0];
      csr_pkg::ADDR_INSTRETH: old = model_instret[63:32];
      // cycle low word is checked in take_response
      csr_pkg::ADDR_CYCLE, csr_pkg::ADDR_CYCLEH: old = '0;
      default: begin
         old = '0;
         known = 1'b0;
      end
   endcase
   rd_en = !(f3[1:0] == 2'b01 && req.instr[11:7] == 5'd0);
   wr_en = !(f3[1:0] != 2'b01 && rs1 == 5'd0);
   legal = req.instr[6:0] == csr_pkg::OPCODE_SYSTEM && f3[1:0] != 2'b00 && known
           && !(wr_en && addr[11:10] == 2'b11);
   case (f3[1:0])
      2'b10:   nv = old | opnd;
      2'b11:   nv = old & ~opnd;
      default: nv = opnd;
   endcase
   if (legal && wr_en) begin
      case (addr)
         csr_pkg::ADDR_SSTATUS: begin
            model_mstatus = (model_mstatus & ~(csr_pkg::SSTATUS_MASK & csr_pkg::MSTATUS_WMASK))
                            | (nv & csr_pkg::SSTATUS_MASK & csr_pkg::MSTATUS_WMASK);
         end
         csr_pkg::ADDR_SIE: begin
            model_mie = (model_mie & ~(model_mideleg & csr_pkg::MIE_WMASK))
                        | (nv & model_mideleg & csr_pkg::MIE_WMASK);
         end
         csr_pkg::ADDR_MSTATUS: begin
            model_mstatus = (model_mstatus & ~csr_pkg::MSTATUS_WMASK)
                            | (nv & csr_pkg::MSTATUS_WMASK);
         end
         csr_pkg::ADDR_MEDELEG: begin
            model_medeleg = (model_medeleg & ~csr_pkg::MEDELEG_WMASK)
                            | (nv & csr_pkg::MEDELEG_WMASK);
         end
         csr_pkg::ADDR_MIDELEG: begin
            model_mideleg = (model_mideleg & ~csr_pkg::MIDELEG_WMASK)
                            | (nv & csr_pkg::MIDELEG_WMASK);
         end
         csr_pkg::ADDR_MIE: begin
            model_mie = (model_mie & ~csr_pkg::MIE_WMASK) | (nv & csr_pkg::MIE_WMASK);
         end
         csr_pkg::ADDR_MTVEC:    model_mtvec = (nv[1:0] < 2'd2) ? nv : model_mtvec;
         csr_pkg::ADDR_MSCRATCH: model_mscratch = nv;
         csr_pkg::ADDR_MEPC:     model_mepc = nv;
         csr_pkg::ADDR_MCAUSE:   model_mcause = nv;
         csr_pkg::ADDR_MTVAL:    model_mtval = nv;
         default: ;
      endcase
   end
   if (legal) begin
      model_instret = model_instret + 64'd1;
   end
   r.rd = req.instr[11:7];
   r.rd_value = (legal && rd_en) ? old : '0;
   r.write_rd = legal && rd_en;
   r.illegal = !legal;
   return r;
endfunction

`endif

/* tests/csr_unit_tb.sv */
`timescale 1ns/100ps

module csr_unit_tb;
   import csr_pkg::*;

   localparam int SEED       = 34059;
   localparam int NUM_REQS   = 74 + 40 + 30 + 29 + 18 + 60;
   localparam int MAX_CYCLES = 8 * NUM_REQS + 200;
   localparam logic [XLEN-1:0] HART_ID = 32'h00000005;

   logic      clk;
   logic      rstn;
   logic      req_valid;
   logic      req_ready;
   csr_req_t  req;
   logic      resp_valid;
   logic      resp_ready;
   csr_resp_t resp;

   int          seed;
   int          ready_seed;
   logic [31:0] ready_draw;
   bit          random_ready;
   int          cycles = 0;
   int          checks = 0;
   int          errors = 0;
   int          tests = 0;
   int          test_errors = 0;
   logic [31:0] last_cycle = '0;

   csr_resp_t             exp_q[$];
   logic [CSR_ADDR_W-1:0] addr_q[$];
   // 0..8 writable, 9..10 views, 11 misa, 12..16 read-only
   logic [CSR_ADDR_W-1:0] listed [17];
   int                    view_idx [5] = '{0, 2, 3, 9, 10};

   `include "csr_model.svh"

   csr_unit #(.HART_ID(HART_ID)) DUT (
      .clk        (clk),
      .rstn       (rstn),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp       (resp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, %0d responses still missing", cycles, exp_q.size());
         $display("Result: FAILED");
         $finish;
      end
   end

   // random back-pressure only in the last test
   always @(negedge clk) begin
      if (random_ready) begin
         ready_draw = $random(ready_seed);
         resp_ready = ready_draw[0];
      end else begin
         resp_ready = 1'b1;
      end
   end

   always @(posedge clk) begin
      if (!rstn && resp_valid && resp_ready) begin
         take_response(resp);
      end
   end

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////
   task automatic check_resp(input csr_resp_t got, input csr_resp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL resp: rd=%h rd_value=%h write_rd=%h illegal=%h, expected %h %h %h %h",
                  got.rd, got.rd_value, got.write_rd, got.illegal,
                  exp.rd, exp.rd_value, exp.write_rd, exp.illegal);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic take_response(input csr_resp_t got);
      csr_resp_t             exp;
      logic [CSR_ADDR_W-1:0] addr;
      if (exp_q.size() == 0) begin
         errors++;
         $display("a response arrived with no request outstanding");
      end else begin
         exp = exp_q.pop_front();
         addr = addr_q.pop_front();
         // cycle low word only has to move forward
         if (exp.write_rd && addr == ADDR_CYCLE) begin
            checks++;
            if (got.rd_value < last_cycle) begin
               errors++;
               $display("FAIL cycle: got %h after %h", got.rd_value, last_cycle);
            end
            last_cycle = got.rd_value;
            exp.rd_value = got.rd_value;
         end
         if (exp.write_rd && addr == ADDR_MISA) begin
            check_word("misa", got.rd_value, MISA_VALUE);
         end
         if (exp.write_rd && addr == ADDR_MHARTID) begin
            check_word("mhartid", got.rd_value, HART_ID);
         end
         check_resp(got, exp);
      end
   endtask

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////
   function automatic csr_req_t make_req(input logic [CSR_ADDR_W-1:0] addr,
                                         input logic [2:0] funct3, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [31:0] value);
      csr_req_t r;
      r.instr = {addr, rs1, funct3, rd, OPCODE_SYSTEM};
      r.rs1_value = value;
      return r;
   endfunction

   // any of the six csr forms
   function automatic logic [2:0] rand_funct3(input logic [31:0] r);
      return {r[2], (r[1:0] == 2'b00) ? 2'b01 : r[1:0]};
   endfunction

   task automatic send_req(input csr_req_t r);
      req_valid = 1'b1;
      req = r;
      @(posedge clk);
      while (!req_ready) begin
         @(posedge clk);
      end
      exp_q.push_back(predict_resp(r));
      addr_q.push_back(r.instr[31:20]);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic finish_test(input string name);
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      @(negedge clk);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
      test_errors = errors;
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////
   task automatic test_write_read();
      logic [31:0] v;
      logic [31:0] r;
      for (int round = 0; round < 4; round++) begin
         for (int i = 0; i < 9; i++) begin
            v = $random(seed);
            r = $random(seed);
            send_req(make_req(listed[i], 3'b001, r[9:5], r[4:0] | 5'd1, v));
            send_req(make_req(listed[i], 3'b010, 5'd0, r[14:10] | 5'd1, r));
         end
      end
      // mtvec mode 2 or 3 is dropped
      v = $random(seed);
      send_req(make_req(ADDR_MTVEC, 3'b001, 5'd1, 5'd1, {v[31:2], 1'b1, v[0]}));
      send_req(make_req(ADDR_MTVEC, 3'b010, 5'd0, 5'd2, '0));
   endtask

   // pool 0 writable, 1 views, 2 everything with gaps
   task automatic random_ops(input int count, input int pool);
      logic [31:0]           r;
      logic [31:0]           v;
      logic [4:0]            rs1;
      logic [4:0]            rd;
      logic [CSR_ADDR_W-1:0] addr;
      for (int n = 0; n < count; n++) begin
         r = $random(seed);
         v = $random(seed);
         rs1 = (r[7:6] == 2'b00) ? 5'd0 : r[12:8];
         rd = (r[14:13] == 2'b00) ? 5'd0 : r[19:15];
         case (pool)
            0:       addr = listed[int'(r[27:20]) % 9];
            1:       addr = listed[view_idx[int'(r[27:20]) % 5]];
            default: addr = (r[31:28] == 4'hf) ? 12'h5c0 : listed[int'(r[27:20]) % 17];
         endcase
         send_req(make_req(addr, rand_funct3(r), rs1, rd, v));
         if (pool == 2 && r[5]) begin
            @(negedge clk);
         end
      end
   endtask

   task automatic test_illegal();
      logic [31:0] r;
      logic [31:0] v;
      csr_req_t    rq;
      for (int n = 0; n < 5; n++) begin
         r = $random(seed);
         v = $random(seed);
         rq = make_req(listed[int'(r[27:20]) % 9], 3'b001, r[12:8], 5'd3, v);
         // an op-format word instead of system
         rq.instr[6:0] = 7'b0110011;
         send_req(rq);
         send_req(make_req(listed[int'(r[27:20]) % 9], r[0] ? 3'b000 : 3'b100,
                           r[12:8], 5'd4, v));
         send_req(make_req(12'h5c0 | {8'h00, r[3:0]}, 3'b010, r[12:8], 5'd5, v));
         send_req(make_req(listed[12 + int'(r[27:20]) % 5], 3'b001, r[12:8], 5'd6, v));
      end
      for (int i = 0; i < 9; i++) begin
         send_req(make_req(listed[i], 3'b010, 5'd0, 5'd7, '0));
      end
   endtask

   task automatic test_constants();
      for (int round = 0; round < 3; round++) begin
         for (int i = 11; i < 17; i++) begin
            send_req(make_req(listed[i], 3'b010, 5'd0, 5'd8, '0));
         end
      end
   endtask

   initial begin
      seed = SEED;
      ready_seed = SEED + 1;
      random_ready = 1'b0;
      rstn = 1'b1;
      req_valid = 1'b0;
      req = '0;
      resp_ready = 1'b1;
      listed = '{ADDR_MSTATUS, ADDR_MEDELEG, ADDR_MIDELEG, ADDR_MIE, ADDR_MTVEC,
                 ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL,
                 ADDR_SSTATUS, ADDR_SIE, ADDR_MISA, ADDR_MHARTID,
                 ADDR_CYCLE, ADDR_CYCLEH, ADDR_INSTRET, ADDR_INSTRETH};
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b0;

      test_write_read();
      finish_test("write then read");
      random_ops(40, 0);
      finish_test("set clear and immediates");
      random_ops(30, 1);
      finish_test("sstatus and sie views");
      test_illegal();
      finish_test("illegal requests");
      test_constants();
      finish_test("constants and counters");
      random_ready = 1'b1;
      random_ops(60, 2);
      finish_test("random back-pressure");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* source/csr_unit.sv */
`timescale 1ns/100ps

module csr_unit #(
   parameter logic [csr_pkg::XLEN-1:0] HART_ID    = '0,
   parameter int                       RESP_DEPTH = 2
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               req_valid,
   output logic               req_ready,
   input  csr_pkg::csr_req_t  req,
   output logic               resp_valid,
   input  logic               resp_ready,
   output csr_pkg::csr_resp_t resp
);
   import csr_pkg::*;

   csr_op_t   op;
   logic      done_valid;
   csr_resp_t done;
   logic      advance;

   // one shared stall for all stage registers
   assign req_ready = advance;

   csr_decode u_decode (
      .clk       (clk),
      .rstn      (rstn),
      .advance   (advance),
      .req_valid (req_valid),
      .req       (req),
      .op        (op)
   );

   csr_execute #(.HART_ID(HART_ID)) u_execute (
      .clk        (clk),
      .rstn       (rstn),
      .advance    (advance),
      .op         (op),
      .done_valid (done_valid),
      .done       (done)
   );

   csr_result #(.RESP_DEPTH(RESP_DEPTH)) u_result (
      .clk        (clk),
      .rstn       (rstn),
      .done_valid (done_valid),
      .done       (done),
      .advance    (advance),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

endmodule

/* source/csr_result.sv */
`timescale 1ns/100ps

module csr_result #(
   parameter int RESP_DEPTH = 2
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               done_valid,
   input  csr_pkg::csr_resp_t done,
   output logic               advance,
   output logic               resp_valid,
   output csr_pkg::csr_resp_t resp,
   input  logic               resp_ready
);
   import csr_pkg::*;

   localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam int CNT_W = $clog2(RESP_DEPTH + 1);

   csr_resp_t        queue_mem [RESP_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign pop        = resp_valid && resp_ready;
   // stall the pipe when the queue stays full after this pop
   assign advance    = (count != CNT_W'(RESP_DEPTH)) || pop;
   assign push       = done_valid && advance;
   assign resp_valid = (count != '0);
   assign resp       = queue_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         queue_mem[wr_ptr] <= done;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // pushes never overfill the queue
   assert property (@(posedge clk) disable iff (rstn)
      count <= CNT_W'(RESP_DEPTH));

   // held response must not change under back-pressure
   assert property (@(posedge clk) disable iff (rstn)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)));

endmodule

/* source/csr_execute.sv */
`timescale 1ns/100ps

module csr_execute #(
   parameter logic [csr_pkg::XLEN-1:0] HART_ID = '0
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               advance,
   input  csr_pkg::csr_op_t   op,
   output logic               done_valid,
   output csr_pkg::csr_resp_t done
);
   import csr_pkg::*;

   localparam logic [XLEN-1:0] SSTATUS_WMASK = SSTATUS_MASK & MSTATUS_WMASK;

   logic [XLEN-1:0] mstatus;
   logic [XLEN-1:0] medeleg;
   logic [XLEN-1:0] mideleg;
   logic [XLEN-1:0] mie;
   logic [XLEN-1:0] mtvec;
   logic [XLEN-1:0] mscratch;
   logic [XLEN-1:0] mepc;
   logic [XLEN-1:0] mcause;
   logic [XLEN-1:0] mtval;
   logic [63:0]     cycle;
   logic [63:0]     instret;

   logic [XLEN-1:0] old_value;
   logic [XLEN-1:0] new_value;
   logic            op_fire;
   logic            write_en;

   function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0] old,
                                             input logic [XLEN-1:0] value,
                                             input logic [XLEN-1:0] mask);
      return (old & ~mask) | (value & mask);
   endfunction

   assign op_fire  = op.valid && advance;
   assign write_en = op_fire && op.legal && op.do_write;

   //////////////////////////////////////////////////
   // read and modify
   //////////////////////////////////////////////////
   always_comb begin
      case (op.addr)
         ADDR_SSTATUS:  old_value = mstatus & SSTATUS_MASK;
         ADDR_SIE:      old_value = mie & mideleg;
         ADDR_MSTATUS:  old_value = mstatus;
         ADDR_MISA:     old_value = MISA_VALUE;
         ADDR_MEDELEG:  old_value = medeleg;
         ADDR_MIDELEG:  old_value = mideleg;
         ADDR_MIE:      old_value = mie;
         ADDR_MTVEC:    old_value = mtvec;
         ADDR_MSCRATCH: old_value = mscratch;
         ADDR_MEPC:     old_value = mepc;
         ADDR_MCAUSE:   old_value = mcause;
         ADDR_MTVAL:    old_value = mtval;
         ADDR_MHARTID:  old_value = HART_ID;
         ADDR_CYCLE:    old_value = cycle[31:0];
         ADDR_CYCLEH:   old_value = cycle[63:32];
         ADDR_INSTRET:  old_value = instret[31:0];
         ADDR_INSTRETH: old_value = instret[63:32];
         default:       old_value = '0;
      endcase
   end

   always_comb begin
      case (op.op)
         CSR_SET:   new_value = old_value | op.operand;
         CSR_CLEAR: new_value = old_value & ~op.operand;
         default:   new_value = op.operand;
      endcase
   end

   //////////////////////////////////////////////////
   // csr state
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus  <= '0;
         medeleg  <= '0;
         mideleg  <= '0;
         mie      <= '0;
         mtvec    <= '0;
         mscratch <= '0;
         mepc     <= '0;
         mcause   <= '0;
         mtval    <= '0;
         cycle    <= '0;
         instret  <= '0;
      end else begin
         cycle <= cycle + 64'd1;
         if (op_fire && op.legal) begin
            instret <= instret + 64'd1;
         end
         if (write_en) begin
            case (op.addr)
               ADDR_SSTATUS:  mstatus  <= merge(mstatus, new_value, SSTATUS_WMASK);
               ADDR_SIE:      mie      <= merge(mie, new_value, mideleg & MIE_WMASK);
               ADDR_MSTATUS:  mstatus  <= merge(mstatus, new_value, MSTATUS_WMASK);
               ADDR_MEDELEG:  medeleg  <= merge(medeleg, new_value, MEDELEG_WMASK);
               ADDR_MIDELEG:  mideleg  <= merge(mideleg, new_value, MIDELEG_WMASK);
               ADDR_MIE:      mie      <= merge(mie, new_value, MIE_WMASK);
               ADDR_MSCRATCH: mscratch <= new_value;
               ADDR_MEPC:     mepc     <= new_value;
               ADDR_MCAUSE:   mcause   <= new_value;
               ADDR_MTVAL:    mtval    <= new_value;
               ADDR_MTVEC: begin
                  // only direct and vectored modes
                  if (new_value[1:0] < 2'd2) begin
                     mtvec <= new_value;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // response stage
   always_ff @(posedge clk) begin
      if (rstn) begin
         done_valid <= 1'b0;
      end else if (advance) begin
         done_valid <= op.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         done.rd       <= op.rd;
         done.rd_value <= (op.legal && op.do_read) ? old_value : '0;
         done.write_rd <= op.legal && op.do_read;
         done.illegal  <= !op.legal;
      end
   end

   // an illegal op leaves every architectural register untouched
   assert property (@(posedge clk) disable iff (rstn)
      (op_fire && !op.legal) |=>
         $stable({mstatus, medeleg, mideleg, mie, mtvec, mscratch,
                  mepc, mcause, mtval, instret}));

endmodule

/* source/csr_decode.sv */
`timescale 1ns/100ps

module csr_decode (
   input  logic              clk,
   input  logic              rstn,
   input  logic              advance,
   input  logic              req_valid,
   input  csr_pkg::csr_req_t req,
   output csr_pkg::csr_op_t  op
);
   import csr_pkg::*;

   logic [6:0]            opcode;
   logic [REG_IDX_W-1:0]  rd;
   logic [2:0]            funct3;
   logic [REG_IDX_W-1:0]  rs1_field;
   logic [CSR_ADDR_W-1:0] addr;
   logic                  addr_listed;
   logic                  read_only;
   csr_op_t               op_next;

   // instruction fields
   assign opcode    = req.instr[6:0];
   assign rd        = req.instr[11:7];
   assign funct3    = req.instr[14:12];
   assign rs1_field = req.instr[19:15];
   assign addr      = req.instr[31:20];

   assign read_only = (addr[11:10] == 2'b11);

   always_comb begin
      case (addr)
         ADDR_SSTATUS, ADDR_SIE, ADDR_MSTATUS, ADDR_MISA,
         ADDR_MEDELEG, ADDR_MIDELEG, ADDR_MIE, ADDR_MTVEC,
         ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL,
         ADDR_MHARTID, ADDR_CYCLE, ADDR_CYCLEH,
         ADDR_INSTRET, ADDR_INSTRETH: addr_listed = 1'b1;
         default:                     addr_listed = 1'b0;
      endcase
   end

   always_comb begin
      op_next       = '0;
      op_next.valid = req_valid;
      op_next.addr  = addr;
      op_next.rd    = rd;
      case (funct3[1:0])
         2'b10:   op_next.op = CSR_SET;
         2'b11:   op_next.op = CSR_CLEAR;
         default: op_next.op = CSR_WRITE;
      endcase
      // immediate forms carry the rs1 field as a 5-bit zero-extended value
      op_next.operand = funct3[2] ? {{(XLEN-REG_IDX_W){1'b0}}, rs1_field} : req.rs1_value;
      // csrrw with rd zero skips the read, csrrs/csrrc with rs1 zero skip the write
      op_next.do_read  = !(op_next.op == CSR_WRITE && rd == '0);
      op_next.do_write = !(op_next.op != CSR_WRITE && rs1_field == '0);
      op_next.legal    = (opcode == OPCODE_SYSTEM) && (funct3[1:0] != 2'b00) && addr_listed
                         && !(op_next.do_write && read_only);
   end

   // stage register
   always_ff @(posedge clk) begin
      if (rstn) begin
         op.valid <= 1'b0;
      end else if (advance) begin
         op <= op_next;
      end
   end

endmodule

/* source/csr_pkg.sv */
package csr_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;
   localparam int REG_IDX_W  = 5;

   localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

   //////////////////////////////////////////////////
   // csr addresses
   //////////////////////////////////////////////////
   // supervisor views onto machine state
   localparam logic [CSR_ADDR_W-1:0] ADDR_SSTATUS  = 12'h100;
   localparam logic [CSR_ADDR_W-1:0] ADDR_SIE      = 12'h104;

   localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MEDELEG  = 12'h302;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIDELEG  = 12'h303;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;

   // read-only space, top two address bits set
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID  = 12'hf14;
   localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLE    = 12'hc00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_CYCLEH   = 12'hc80;
   localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRET  = 12'hc02;
   localparam logic [CSR_ADDR_W-1:0] ADDR_INSTRETH = 12'hc82;

   //////////////////////////////////////////////////
   // write masks and constants
   //////////////////////////////////////////////////
   localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h601e79aa;
   localparam logic [XLEN-1:0] SSTATUS_MASK  = 32'h800de133;
   localparam logic [XLEN-1:0] MEDELEG_WMASK = 32'h0000bfff;
   localparam logic [XLEN-1:0] MIDELEG_WMASK = 32'h00000222;
   localparam logic [XLEN-1:0] MIE_WMASK     = 32'h00000aaa;
   // rv32 with a, i, m, s, u
   localparam logic [XLEN-1:0] MISA_VALUE    = 32'h40141101;

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////
   // matches funct3[1:0] of the csr instructions
   typedef enum logic [1:0] {
      CSR_WRITE = 2'b01,
      CSR_SET   = 2'b10,
      CSR_CLEAR = 2'b11
   } csr_op_e;

   typedef struct packed {
      logic [XLEN-1:0] instr;
      logic [XLEN-1:0] rs1_value;
   } csr_req_t;

   typedef struct packed {
      logic                  valid;
      logic [CSR_ADDR_W-1:0] addr;
      csr_op_e               op;
      logic [XLEN-1:0]       operand;
      logic [REG_IDX_W-1:0]  rd;
      logic                  do_read;
      logic                  do_write;
      logic                  legal;
   } csr_op_t;

   typedef struct packed {
      logic [REG_IDX_W-1:0] rd;
      logic [XLEN-1:0]      rd_value;
      logic                 write_rd;
      logic                 illegal;
   } csr_resp_t;

endpackage
